// ==== hilbertTransform.f ====
src/hilbertPkg.sv
src/coeffSetup.sv
src/hilbertControl.sv
src/hilbertFir.sv
src/realDelay.sv
src/hilbertTransform.sv
tests/hilbertTransformTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the Hilbert transformer testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log
simName=hilbertTransformSim

verilator --binary --timing --top-module hilbertTransformTb \
	-f hilbertTransform.f --Mdir "$buildDir" -o "$simName"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$buildDir/$simName" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Something failed" "$logFile"; then
	exit 1
fi
exit 0

// ==== src/coeffSetup.sv ====
module coeffSetup (
	input logic clock,
	input logic rstN,
	input logic loadStart,
	output logic coeffShift,
	output hilbertPkg::coeffT coeffWord,
	output logic coeffSetFlag
);

	// index of the word currently on coeffWord
	hilbertPkg::tapIndexT index;
	// high while the table is being streamed
	logic active;
	logic lastWord;

	// last table entry reached
	assign lastWord = (index == hilbertPkg::tapIndexT'(hilbertPkg::tapCount - 1));

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			active <= 1'b0;
			index <= '0;
		end else if (loadStart) begin
			// restart from the first tap
			active <= 1'b1;
			index <= '0;
		end else if (active) begin
			if (lastWord) begin
				active <= 1'b0;
			end else begin
				index <= index + 1'b1;
			end
		end
	end

	// one shift per cycle, tapCount cycles in all
	assign coeffShift = active;

	// table word for the current index
	assign coeffWord = hilbertPkg::hilbertCoeff[index];

	// flag goes out together with the last word
	assign coeffSetFlag = active && lastWord;

endmodule

// ==== src/hilbertControl.sv ====
module hilbertControl (
	input logic clock,
	input logic rstN,
	input logic enable,
	input logic stopDataIn,
	input logic coeffSetFlag,
	output logic loadStart,
	output logic sampleTake,
	output logic zeroFeed,
	output logic flushDone
);

	hilbertPkg::hilbertStateT state;
	hilbertPkg::hilbertStateT nextState;
	// zero samples fed so far in flush
	hilbertPkg::tapIndexT flushCount;
	logic flushLast;

	// tail is tapCount-1 samples long
	assign flushLast = (flushCount == hilbertPkg::tapIndexT'(hilbertPkg::tapCount - 2));

	always_comb begin
		nextState = state;
		case (state)
			hilbertPkg::idleState: begin
				// enable only matters here
				if (enable) begin
					nextState = hilbertPkg::loadCoeffState;
				end
			end
			hilbertPkg::loadCoeffState: begin
				// coefficient stream done
				if (coeffSetFlag) begin
					nextState = hilbertPkg::mainOpState;
				end
			end
			hilbertPkg::mainOpState: begin
				if (stopDataIn) begin
					nextState = hilbertPkg::flushState;
				end
			end
			hilbertPkg::flushState: begin
				if (flushLast) begin
					nextState = hilbertPkg::stopState;
				end
			end
			hilbertPkg::stopState: begin
				nextState = hilbertPkg::idleState;
			end
			default: begin
				nextState = hilbertPkg::idleState;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= hilbertPkg::idleState;
			flushCount <= '0;
		end else begin
			state <= nextState;
			// counter runs only while flushing
			if (state == hilbertPkg::flushState) begin
				flushCount <= flushCount + 1'b1;
			end else begin
				flushCount <= '0;
			end
		end
	end

	// start the table stream on the same edge that leaves idle
	assign loadStart = (state == hilbertPkg::idleState) && enable;

	// one sample per clock in main operation and flush
	assign sampleTake = (state == hilbertPkg::mainOpState) || (state == hilbertPkg::flushState);

	// flush pushes zeros through the tap lines
	assign zeroFeed = (state == hilbertPkg::flushState);

	// single cycle in stop
	assign flushDone = (state == hilbertPkg::stopState);

endmodule

// ==== src/hilbertFir.sv ====
module hilbertFir (
	input logic clock,
	input logic rstN,
	input logic loadStart,
	input logic coeffShift,
	input hilbertPkg::coeffT coeffWord,
	input logic sampleTake,
	input logic zeroFeed,
	input hilbertPkg::sampleT dataIn,
	output hilbertPkg::outSampleT imOut,
	output logic outValid
);

	// coeffReg[i] multiplies tapLine[i]
	hilbertPkg::coeffT coeffReg [0:hilbertPkg::tapCount-1];
	// tapLine[0] is the newest sample
	hilbertPkg::sampleT tapLine [0:hilbertPkg::tapCount-1];
	hilbertPkg::productT product [0:hilbertPkg::tapCount-1];
	hilbertPkg::accT sumComb;
	hilbertPkg::accT sumReg;
	hilbertPkg::sampleT feedSample;
	// bit 0 tracks the tap line, then products, sum and output
	logic [hilbertPkg::firLatency:0] validPipe;

	// zeros during flush
	assign feedSample = zeroFeed ? '0 : dataIn;

	// coefficients enter at the top and move down
	// so the first word streamed ends up in coeffReg[0]
	always_ff @(posedge clock) begin
		if (coeffShift) begin
			for (int i = 0; i < hilbertPkg::tapCount - 1; i++) begin
				coeffReg[i] <= coeffReg[i+1];
			end
			coeffReg[hilbertPkg::tapCount-1] <= coeffWord;
		end
	end

	// sample history
	always_ff @(posedge clock) begin
		if (loadStart) begin
			// every run starts with empty history
			for (int i = 0; i < hilbertPkg::tapCount; i++) begin
				tapLine[i] <= '0;
			end
		end else if (sampleTake) begin
			tapLine[0] <= feedSample;
			for (int i = 1; i < hilbertPkg::tapCount; i++) begin
				tapLine[i] <= tapLine[i-1];
			end
		end
	end

	// stage 1, one product per tap
	always_ff @(posedge clock) begin
		for (int i = 0; i < hilbertPkg::tapCount; i++) begin
			product[i] <= coeffReg[i] * tapLine[i];
		end
	end

	// adder tree, full width so it cannot wrap
	always_comb begin
		sumComb = '0;
		for (int i = 0; i < hilbertPkg::tapCount; i++) begin
			sumComb = sumComb + product[i];
		end
	end

	// stage 2, registered sum
	always_ff @(posedge clock) begin
		sumReg <= sumComb;
	end

	// stage 3, drop the fraction bits and hold zero between valid samples
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			validPipe <= '0;
			imOut <= '0;
		end else begin
			validPipe <= {validPipe[hilbertPkg::firLatency-1:0], sampleTake};
			if (validPipe[hilbertPkg::firLatency-1]) begin
				// arithmetic shift keeps the sign, the cast truncates
				imOut <= hilbertPkg::outSampleT'(sumReg >>> hilbertPkg::coeffFracBits);
			end else begin
				imOut <= '0;
			end
		end
	end

	// valid lines up with imOut
	assign outValid = validPipe[hilbertPkg::firLatency];

endmodule

// ==== src/hilbertPkg.sv ====
package hilbertPkg;

	// filter geometry
	localparam int tapCount = 27;
	// centre tap index, equal to the group delay in samples
	localparam int tapCentre = (tapCount - 1) / 2;
	// register stages after the tap line: products, sum, output
	localparam int firLatency = 3;

	// datapath widths
	localparam int sampleWidth = 16;
	localparam int coeffWidth = 18;
	// coefficients are Q2.16
	localparam int coeffFracBits = 16;
	// two bits above the input cover the worst-case gain of about 2.5
	localparam int outWidth = 18;
	localparam int productWidth = sampleWidth + coeffWidth;
	// full precision sum of all taps
	localparam int accWidth = productWidth + $clog2(tapCount);

	typedef logic signed [sampleWidth-1:0] sampleT;
	typedef logic signed [coeffWidth-1:0] coeffT;
	typedef logic signed [outWidth-1:0] outSampleT;
	typedef logic signed [productWidth-1:0] productT;
	typedef logic signed [accWidth-1:0] accT;
	typedef logic [$clog2(tapCount)-1:0] tapIndexT;

	// ideal response 2/(pi*k) at odd offsets k from the centre, zero at even offsets
	// rounded to 16 fraction bits, negative before the centre
	localparam coeffT hilbertCoeff [0:tapCount-1] = '{
		-18'sd3209, 18'sd0, -18'sd3793, 18'sd0,
		-18'sd4636, 18'sd0, -18'sd5960, 18'sd0,
		-18'sd8344, 18'sd0, -18'sd13907, 18'sd0,
		-18'sd41722,
		// centre tap
		18'sd0,
		18'sd41722,
		18'sd0, 18'sd13907, 18'sd0, 18'sd8344,
		18'sd0, 18'sd5960, 18'sd0, 18'sd4636,
		18'sd0, 18'sd3793, 18'sd0, 18'sd3209
	};

	// run sequencing
	typedef enum logic [2:0] {
		idleState,
		loadCoeffState,
		mainOpState,
		flushState,
		stopState
	} hilbertStateT;

	// one analytic output sample
	typedef struct packed {
		outSampleT re;
		outSampleT im;
		logic valid;
	} analyticT;

endpackage

// ==== src/hilbertTransform.sv ====
module hilbertTransform (
	input logic clock,
	input logic rstN,
	input logic enable,
	input logic stopDataIn,
	input hilbertPkg::sampleT dataIn,
	output hilbertPkg::analyticT analyticOut,
	output logic flushDone
);

	// control to datapath
	logic loadStart;
	logic sampleTake;
	logic zeroFeed;

	// coefficient stream
	logic coeffShift;
	logic coeffSetFlag;
	hilbertPkg::coeffT coeffWord;

	// outputs of the two paths
	hilbertPkg::outSampleT reOut;
	hilbertPkg::outSampleT imOut;
	logic outValid;

	hilbertControl hilbertControlInst (
		.clock(clock),
		.rstN(rstN),
		.enable(enable),
		.stopDataIn(stopDataIn),
		.coeffSetFlag(coeffSetFlag),
		.loadStart(loadStart),
		.sampleTake(sampleTake),
		.zeroFeed(zeroFeed),
		.flushDone(flushDone)
	);

	coeffSetup coeffSetupInst (
		.clock(clock),
		.rstN(rstN),
		.loadStart(loadStart),
		.coeffShift(coeffShift),
		.coeffWord(coeffWord),
		.coeffSetFlag(coeffSetFlag)
	);

	// imaginary path
	hilbertFir hilbertFirInst (
		.clock(clock),
		.rstN(rstN),
		.loadStart(loadStart),
		.coeffShift(coeffShift),
		.coeffWord(coeffWord),
		.sampleTake(sampleTake),
		.zeroFeed(zeroFeed),
		.dataIn(dataIn),
		.imOut(imOut),
		.outValid(outValid)
	);

	// real path, timed off the filter's valid
	realDelay realDelayInst (
		.clock(clock),
		.rstN(rstN),
		.loadStart(loadStart),
		.sampleTake(sampleTake),
		.zeroFeed(zeroFeed),
		.dataIn(dataIn),
		.outValid(outValid),
		.reOut(reOut)
	);

	// both halves leave on the same cycle
	assign analyticOut.re = reOut;
	assign analyticOut.im = imOut;
	assign analyticOut.valid = outValid;

endmodule

// ==== src/realDelay.sv ====
module realDelay (
	input logic clock,
	input logic rstN,
	input logic loadStart,
	input logic sampleTake,
	input logic zeroFeed,
	input hilbertPkg::sampleT dataIn,
	input logic outValid,
	output hilbertPkg::outSampleT reOut
);

	// centre delay, line[tapCentre-1] holds the sample tapCentre takes back
	hilbertPkg::sampleT line [0:hilbertPkg::tapCentre-1];
	// alignPipe[0] matches the filter tap line, the rest match its pipeline
	hilbertPkg::sampleT alignPipe [0:hilbertPkg::firLatency];
	hilbertPkg::sampleT feedSample;

	assign feedSample = zeroFeed ? '0 : dataIn;

	// centre line advances only on taken samples
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < hilbertPkg::tapCentre; i++) begin
				line[i] <= '0;
			end
		end else if (loadStart) begin
			// zero history for each run, same as the filter
			for (int i = 0; i < hilbertPkg::tapCentre; i++) begin
				line[i] <= '0;
			end
		end else if (sampleTake) begin
			line[0] <= feedSample;
			for (int i = 1; i < hilbertPkg::tapCentre; i++) begin
				line[i] <= line[i-1];
			end
		end
	end

	// free running, sampled before the line shifts so the delay is exactly tapCentre
	always_ff @(posedge clock) begin
		alignPipe[0] <= line[hilbertPkg::tapCentre-1];
		for (int i = 1; i <= hilbertPkg::firLatency; i++) begin
			alignPipe[i] <= alignPipe[i-1];
		end
	end

	// sign extended, zero outside valid output slots
	assign reOut = outValid ? hilbertPkg::outSampleT'(alignPipe[hilbertPkg::firLatency]) : '0;

endmodule

// ==== tests/hilbertTransformTb.sv ====
module hilbertTransformTb;

	logic clock;
	logic rstN;
	logic enable;
	logic stopDataIn;
	hilbertPkg::sampleT dataIn;
	hilbertPkg::analyticT analyticOut;
	logic flushDone;

	// samples of the current run, oldest first
	int history[$];
	// samples for the next run
	int stimulus[$];
	// expected outputs in the order they must appear
	hilbertPkg::analyticT expectQueue[$];
	hilbertPkg::analyticT expectedOut;

	logic [31:0] lfsrState;
	int errorCount;
	int checkCount;
	int validCount;
	int doneCount;
	int cycleCount;
	int timeoutLimit;
	// largest im magnitude seen on a valid output
	int imPeak;

	hilbertTransform hilbertTransform_inst (
		.clock(clock),
		.rstN(rstN),
		.enable(enable),
		.stopDataIn(stopDataIn),
		.dataIn(dataIn),
		.analyticOut(analyticOut),
		.flushDone(flushDone)
	);

	always #10 clock = ~clock;

	// one Galois step, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h80200003;
		end
		return state >> 1;
	endfunction

	// 16 steps, one per sample bit
	function automatic int randomSample();
		logic [15:0] bits;
		bits = '0;
		for (int b = 0; b < 16; b++) begin
			bits = {bits[14:0], lfsrState[0]};
			lfsrState = lfsrStep(lfsrState);
		end
		return int'($signed(bits));
	endfunction

	// expected output n of the current run, missing history counts as zero
	function automatic hilbertPkg::analyticT referenceOutput(input int n);
		hilbertPkg::analyticT result;
		longint acc;
		acc = 0;
		for (int i = 0; i < hilbertPkg::tapCount; i++) begin
			if (n >= i) begin
				acc += longint'(hilbertPkg::hilbertCoeff[i]) * longint'(history[n-i]);
			end
		end
		result.valid = 1'b1;
		// drop 16 fraction bits, keep the low output bits
		result.im = hilbertPkg::outSampleT'(acc >>> 16);
		if (n >= hilbertPkg::tapCentre) begin
			result.re = hilbertPkg::outSampleT'(history[n-hilbertPkg::tapCentre]);
		end else begin
			result.re = '0;
		end
		return result;
	endfunction

	// load, flush, stop and drain around the samples themselves
	function automatic int runCycles(input int samples);
		return samples + 2 * hilbertPkg::tapCount + hilbertPkg::firLatency + 10;
	endfunction

	task automatic compareValue(input string name, input longint actual, input longint expected);
		checkCount++;
		if (actual != expected) begin
			errorCount++;
			$display("FAILED %s at %0t: got 0x%0h, expected 0x%0h", name, $time, actual, expected);
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		if (errorCount == errorsBefore) begin
			$display("test %s: pass", name);
		end else begin
			$display("test %s: fail, %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	task automatic pushExpected(input int sample);
		history.push_back(sample);
		expectQueue.push_back(referenceOutput(history.size() - 1));
	endtask

	// one full run over stimulus, back in idle when it returns
	task automatic runSamples();
		int startValid;
		int startDone;
		history.delete();
		startValid = validCount;
		startDone = doneCount;
		@(negedge clock);
		enable = 1'b1;
		dataIn = '0;
		@(negedge clock);
		enable = 1'b0;
		// table stream still going
		repeat (hilbertPkg::tapCount - 1) @(negedge clock);
		// first sample lands on the edge after load ends
		for (int n = 0; n < stimulus.size(); n++) begin
			@(negedge clock);
			dataIn = hilbertPkg::sampleT'(stimulus[n]);
			stopDataIn = (n == stimulus.size() - 1);
			pushExpected(stimulus[n]);
		end
		@(negedge clock);
		stopDataIn = 1'b0;
		// must be ignored, flush feeds zeros
		dataIn = 16'sh7fff;
		for (int n = 0; n < hilbertPkg::tapCount - 1; n++) begin
			pushExpected(0);
		end
		while (doneCount == startDone) @(negedge clock);
		while (expectQueue.size() != 0) @(negedge clock);
		// a few more cycles to catch stray valids
		repeat (4) @(negedge clock);
		dataIn = '0;
		compareValue("valid output count", longint'(validCount - startValid),
			longint'(stimulus.size() + hilbertPkg::tapCount - 1));
		compareValue("flushDone pulses", longint'(doneCount - startDone), 64'sd1);
	endtask

	// sampled before the edge updates anything
	always @(posedge clock) begin
		if (rstN) begin
			if (analyticOut.valid) begin
				validCount++;
				// track the swing for the headroom check
				if (int'(analyticOut.im) > imPeak) begin
					imPeak = int'(analyticOut.im);
				end
				if (-int'(analyticOut.im) > imPeak) begin
					imPeak = -int'(analyticOut.im);
				end
				if (expectQueue.size() == 0) begin
					errorCount++;
					$display("valid output at %0t with no expected sample left", $time);
				end else begin
					expectedOut = expectQueue.pop_front();
					compareValue("analyticOut.re", longint'(analyticOut.re), longint'(expectedOut.re));
					compareValue("analyticOut.im", longint'(analyticOut.im), longint'(expectedOut.im));
				end
			end else begin
				// zero between valid samples
				compareValue("analyticOut.re", longint'(analyticOut.re), 64'sd0);
				compareValue("analyticOut.im", longint'(analyticOut.im), 64'sd0);
			end
			if (flushDone) begin
				doneCount++;
			end
		end
	end

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount >= timeoutLimit) begin
			$display("simulation timed out after %0d cycles", cycleCount);
			$display("Something failed");
			$finish;
		end
	end

	initial begin
		int errorsBefore;
		int startValid;
		int startDone;
		clock = 1'b0;
		rstN = 1'b0;
		enable = 1'b0;
		stopDataIn = 1'b0;
		dataIn = '0;
		lfsrState = 32'h401;
		errorCount = 0;
		checkCount = 0;
		validCount = 0;
		doneCount = 0;
		cycleCount = 0;
		imPeak = 0;
		// reset, two idle waits and three runs
		timeoutLimit = 8 + 40 + runCycles(40) + runCycles(300) + runCycles(78) + 200;
		repeat (8) @(negedge clock);
		rstN = 1'b1;

		// quiet while enable stays low
		errorsBefore = errorCount;
		repeat (20) @(negedge clock);
		compareValue("valid output count", longint'(validCount), 64'sd0);
		compareValue("flushDone pulses", longint'(doneCount), 64'sd0);
		reportTest("1 idle after reset", errorsBefore);

		// single impulse, im walks the table scaled by 1/16
		errorsBefore = errorCount;
		stimulus.delete();
		stimulus.push_back(4096);
		repeat (39) stimulus.push_back(0);
		runSamples();
		reportTest("2 impulse response", errorsBefore);

		errorsBefore = errorCount;
		stimulus.delete();
		repeat (300) stimulus.push_back(randomSample());
		runSamples();
		reportTest("3 random samples", errorsBefore);

		// back in idle, nothing moves
		errorsBefore = errorCount;
		startValid = validCount;
		startDone = doneCount;
		repeat (20) @(negedge clock);
		compareValue("valid output count", longint'(validCount - startValid), 64'sd0);
		compareValue("flushDone pulses", longint'(doneCount - startDone), 64'sd0);
		reportTest("4 flush and return to idle", errorsBefore);

		// blocks of 13 line up with the sign of each half of the table
		// 32767 is the largest positive sample
		errorsBefore = errorCount;
		stimulus.delete();
		for (int b = 0; b < 6; b++) begin
			repeat (hilbertPkg::tapCentre) stimulus.push_back((b % 2 == 0) ? 32767 : -32768);
		end
		imPeak = 0;
		runSamples();
		if (imPeak <= 32767) begin
			errorCount++;
			$display("full-scale run never went past the 16-bit range, peak %0d", imPeak);
		end
		reportTest("5 second run, full scale", errorsBefore);

		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule
